// File: src/mmu_settings.svh
`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

`define TLB_ENTRIES 16 // joint TLB size
`define TLB_INDEX_W 4  // log2 of entry count

// only this code maps to a cacheable access, every other code is uncached
`define CCA_CACHED 3'd3

`endif

// File: src/mmuPkg.sv
`default_nettype none

package mmuPkg;

    // cause values follow MIPS (Mod=1, TLBL=2, TLBS=3)
    // bit 4 tells the invalid case apart from the refill case
    typedef enum logic [4:0] {
        noEx         = 5'h00,
        modified     = 5'h01,
        loadRefill   = 5'h02,
        storeRefill  = 5'h03,
        loadInvalid  = 5'h12,
        storeInvalid = 5'h13
    } excCode;

    typedef enum logic {
        idle = 1'b0,
        fill = 1'b1 // buffer loading from joint TLB
    } bufState;

    // one even or odd page of a TLB entry
    typedef struct packed {
        logic [19:0] pfn;
        logic [2:0]  cca;
        logic        dirty; // write allowed
        logic        valid;
    } pageAttr;

endpackage

`default_nettype wire

// File: src/tlbLookupIf.sv
`timescale 1ns/1ps
`default_nettype none

interface tlbLookupIf;

    logic [18:0]     vpn2;  // vaddr[31:13]
    logic            found;
    mmuPkg::pageAttr page0; // even page
    mmuPkg::pageAttr page1; // odd page

    modport requester (
        output vpn2,
        input  found, page0, page1
    );

    modport responder (
        input  vpn2,
        output found, page0, page1
    );

endinterface

`default_nettype wire

// File: src/requestRegister.sv
`timescale 1ns/1ps
`default_nettype none

module requestRegister (
    input  wire         clk,
    input  wire         reset,
    input  wire  [31:0] reqAddr,
    input  wire         reqRead,
    input  wire         reqStore,
    input  wire         stall,
    output logic [31:0] vaddr,
    output logic        read,
    output logic        store
);

    always_ff @(posedge clk) begin
        if (reset) begin
            read  <= 1'b0;
            store <= 1'b0;
        end else if (!stall) begin
            read  <= reqRead;
            store <= reqStore;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            vaddr <= reqAddr; // held while the buffer refills
        end
    end

endmodule

`default_nettype wire

// File: src/tlbArray.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_settings.svh"

module tlbArray (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    tlbWrite,
    input  wire [`TLB_INDEX_W-1:0] tlbWriteIndex,
    input  wire [18:0]             tlbWriteVpn2,
    input  wire mmuPkg::pageAttr   tlbWritePage0,
    input  wire mmuPkg::pageAttr   tlbWritePage1,
    tlbLookupIf.responder          lookup
);

    logic [18:0]            vpn2Mem  [`TLB_ENTRIES];
    mmuPkg::pageAttr        page0Mem [`TLB_ENTRIES];
    mmuPkg::pageAttr        page1Mem [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0] used; // entry written since reset

    always_ff @(posedge clk) begin
        if (reset) begin
            used <= '0;
        end else if (tlbWrite) begin
            used[tlbWriteIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlbWrite) begin
            vpn2Mem[tlbWriteIndex]  <= tlbWriteVpn2;
            page0Mem[tlbWriteIndex] <= tlbWritePage0;
            page1Mem[tlbWriteIndex] <= tlbWritePage1;
        end
    end

    // fully associative search
    // software keeps vpn2 unique, lowest index wins otherwise
    always_comb begin
        logic hit;
        hit          = 1'b0;
        lookup.page0 = '0;
        lookup.page1 = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (!hit && used[i] && (vpn2Mem[i] == lookup.vpn2)) begin
                hit          = 1'b1;
                lookup.page0 = page0Mem[i];
                lookup.page1 = page1Mem[i];
            end
        end
        lookup.found = hit;
    end

endmodule

`default_nettype wire

// File: src/dtlbBuffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_settings.svh"

module dtlbBuffer (
    input  wire            clk,
    input  wire            reset,
    input  wire     [31:0] vaddr,
    input  wire            read,
    input  wire            store,
    input  wire     [2:0]  kseg0Cca,
    input  wire            tlbWrite,
    tlbLookupIf.requester  lookup,
    output logic           stall,
    output logic    [19:0] physPage,
    output logic           uncached,
    output mmuPkg::excCode exc,
    output logic           exception
);

    mmuPkg::bufState state;
    mmuPkg::bufState nextState;

    logic            bufValid;
    logic            bufFound;
    logic [18:0]     bufVpn2;
    mmuPkg::pageAttr bufPage0;
    mmuPkg::pageAttr bufPage1;
    mmuPkg::pageAttr selPage;

    logic [3:0] segment;
    logic       mapped;
    logic       access;
    logic       bufHit;
    logic       bufLoad;

    assign segment = vaddr[31:28];
    assign mapped  = (segment[3:2] != 2'b10); // 8..B is kseg0/kseg1
    assign access  = read | store;
    assign bufHit  = bufValid && (bufVpn2 == vaddr[31:13]);
    assign stall   = mapped && access && !bufHit;

    assign lookup.vpn2 = vaddr[31:13];
    assign selPage     = vaddr[12] ? bufPage1 : bufPage0; // odd or even page

    // stall raised in idle, buffer loads in fill, hit then drops stall
    assign nextState = stall ? mmuPkg::fill : mmuPkg::idle;
    assign bufLoad   = (state == mmuPkg::fill) && stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mmuPkg::idle;
        end else begin
            state <= nextState;
        end
    end

    // a joint TLB write invalidates the copy held here
    always_ff @(posedge clk) begin
        if (reset || tlbWrite) begin
            bufValid <= 1'b0;
        end else if (bufLoad) begin
            bufValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (bufLoad) begin
            bufFound <= lookup.found; // a miss is buffered too
            bufVpn2  <= vaddr[31:13];
            bufPage0 <= lookup.page0;
            bufPage1 <= lookup.page1;
        end
    end

    always_comb begin
        if (segment[3:1] == 3'b101) begin // kseg1
            physPage = {3'b000, vaddr[28:12]};
            uncached = 1'b1;
        end else if (segment[3:1] == 3'b100) begin // kseg0
            physPage = {1'b0, vaddr[30:12]};
            uncached = (kseg0Cca != `CCA_CACHED);
        end else begin
            physPage = selPage.pfn;
            uncached = (selPage.cca != `CCA_CACHED);
        end
    end

    // store level takes priority when both levels are high
    always_comb begin
        if (stall || !mapped || !access) begin
            exc = mmuPkg::noEx;
        end else if (!bufFound) begin
            exc = store ? mmuPkg::storeRefill : mmuPkg::loadRefill;
        end else if (!selPage.valid) begin
            exc = store ? mmuPkg::storeInvalid : mmuPkg::loadInvalid;
        end else if (store && !selPage.dirty) begin
            exc = mmuPkg::modified;
        end else begin
            exc = mmuPkg::noEx;
        end
    end

    assign exception = (exc != mmuPkg::noEx);

endmodule

`default_nettype wire

// File: src/translateOutput.sv
`timescale 1ns/1ps
`default_nettype none

module translateOutput (
    input  wire            clk,
    input  wire            reset,
    input  wire            stall,
    input  wire            read,
    input  wire            store,
    input  wire     [19:0] physPage,
    input  wire     [11:0] offset,
    input  wire            uncached,
    input  wire mmuPkg::excCode exc,
    input  wire            exception,
    output logic           respValid,
    output logic    [31:0] respPhysAddr,
    output logic           respUncached,
    output mmuPkg::excCode respExcCode,
    output logic           respException
);

    logic finish;

    assign finish = !stall && (read || store); // translation done this cycle

    always_ff @(posedge clk) begin
        if (reset) begin
            respValid     <= 1'b0;
            respExcCode   <= mmuPkg::noEx;
            respException <= 1'b0;
        end else begin
            respValid <= finish; // one pulse per request
            if (finish) begin
                respExcCode   <= exc;
                respException <= exception;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (finish) begin
            respPhysAddr <= {physPage, offset};
            respUncached <= uncached;
        end
    end

endmodule

`default_nettype wire

// File: src/dataTranslate.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_settings.svh"

module dataTranslate (
    input  wire                    clk,
    input  wire                    reset,
    input  wire [31:0]             reqAddr,
    input  wire                    reqRead,
    input  wire                    reqStore,
    input  wire [2:0]              kseg0Cca,
    input  wire                    tlbWrite,
    input  wire [`TLB_INDEX_W-1:0] tlbWriteIndex,
    input  wire [18:0]             tlbWriteVpn2,
    input  wire mmuPkg::pageAttr   tlbWritePage0,
    input  wire mmuPkg::pageAttr   tlbWritePage1,
    output logic                   memStall,
    output logic                   respValid,
    output logic [31:0]            respPhysAddr,
    output logic                   respUncached,
    output mmuPkg::excCode         respExcCode,
    output logic                   respException
);

    logic [31:0]    vaddr;
    logic           read;
    logic           store;
    logic [19:0]    physPage;
    logic           uncached;
    mmuPkg::excCode exc;
    logic           exception;

    tlbLookupIf lookup ();

    requestRegister requestReg (
        .clk      (clk),
        .reset    (reset),
        .reqAddr  (reqAddr),
        .reqRead  (reqRead),
        .reqStore (reqStore),
        .stall    (memStall),
        .vaddr    (vaddr),
        .read     (read),
        .store    (store)
    );

    tlbArray jointTlb (
        .clk           (clk),
        .reset         (reset),
        .tlbWrite      (tlbWrite),
        .tlbWriteIndex (tlbWriteIndex),
        .tlbWriteVpn2  (tlbWriteVpn2),
        .tlbWritePage0 (tlbWritePage0),
        .tlbWritePage1 (tlbWritePage1),
        .lookup        (lookup.responder)
    );

    dtlbBuffer dtlb (
        .clk       (clk),
        .reset     (reset),
        .vaddr     (vaddr),
        .read      (read),
        .store     (store),
        .kseg0Cca  (kseg0Cca),
        .tlbWrite  (tlbWrite),
        .lookup    (lookup.requester),
        .stall     (memStall),
        .physPage  (physPage),
        .uncached  (uncached),
        .exc       (exc),
        .exception (exception)
    );

    translateOutput outputReg (
        .clk           (clk),
        .reset         (reset),
        .stall         (memStall),
        .read          (read),
        .store         (store),
        .physPage      (physPage),
        .offset        (vaddr[11:0]), // page offset passes untranslated
        .uncached      (uncached),
        .exc           (exc),
        .exception     (exception),
        .respValid     (respValid),
        .respPhysAddr  (respPhysAddr),
        .respUncached  (respUncached),
        .respExcCode   (respExcCode),
        .respException (respException)
    );

endmodule

`default_nettype wire

// File: verification/dataTranslate_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dataTranslate_checker (
    input wire                 clk,
    input wire                 reset,
    input wire                 memStall,
    input wire                 respValid,
    input wire mmuPkg::excCode respExcCode,
    input wire                 respException
);

    // a refill stalls for exactly two cycles, never longer
    stallLength: assert property (
        @(posedge clk) disable iff (reset)
        (memStall ##1 memStall) |=> !memStall
    ) else $error("memStall stayed high for more than 2 cycles");

    excFlag: assert property (
        @(posedge clk) disable iff (reset)
        respException == (respExcCode != mmuPkg::noEx)
    ) else $error("respException does not match respExcCode");

    resetQuiet: assert property (
        @(posedge clk)
        $fell(reset) |-> (!respValid && !memStall)
    ) else $error("respValid or memStall high right after reset");

endmodule

bind dataTranslate dataTranslate_checker ruleCheck (
    .clk           (clk),
    .reset         (reset),
    .memStall      (memStall),
    .respValid     (respValid),
    .respExcCode   (respExcCode),
    .respException (respException)
);

`default_nettype wire

// File: verification/dataTranslate_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_settings.svh"

module dataTranslate_tb;

    logic clk = 1'b0;
    logic reset, reqRead, reqStore, tlbWrite, memStall, respValid, respUncached, respException;
    logic [31:0] reqAddr, respPhysAddr;
    logic [2:0] kseg0Cca;
    logic [`TLB_INDEX_W-1:0] tlbWriteIndex;
    logic [18:0] tlbWriteVpn2;
    mmuPkg::pageAttr tlbWritePage0, tlbWritePage1;
    mmuPkg::excCode respExcCode;

    mmuPkg::pageAttr mPage0 [16];
    mmuPkg::pageAttr mPage1 [16];
    logic [18:0] mVpn2 [16];
    bit mUsed [16];
    logic [31:0] expAddr [$];
    bit expUnc [$];
    mmuPkg::excCode expExc [$];
    int errors = 0;
    int checks = 0;
    int stallCycles = 0;
    int s0;
    string testName = "reset";
    logic [31:0] seed = 32'hfe5d_9fa4;
    logic [31:0] r;

    dataTranslate UUT (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic mmuPkg::pageAttr page(input [19:0] pfn, input [2:0] cca, input bit d, v);
        return mmuPkg::pageAttr'{pfn, cca, d, v};
    endfunction

    // reference translation from the segment and TLB rules
    task automatic predict(input [31:0] a, input bit st);
        mmuPkg::pageAttr pg;
        bit hit;
        mmuPkg::excCode e;
        pg = '0;
        hit = 1'b0;
        e = mmuPkg::noEx;
        if (a[31:29] == 3'b101) begin
            expAddr.push_back({3'b000, a[28:0]});
            expUnc.push_back(1'b1);
        end else if (a[31:29] == 3'b100) begin
            expAddr.push_back({1'b0, a[30:0]});
            expUnc.push_back(kseg0Cca != `CCA_CACHED);
        end else begin
            for (int i = 0; i < 16; i++) begin
                if (!hit && mUsed[i] && mVpn2[i] == a[31:13]) begin
                    hit = 1'b1;
                    pg = a[12] ? mPage1[i] : mPage0[i];
                end
            end
            if (!hit) e = st ? mmuPkg::storeRefill : mmuPkg::loadRefill;
            else if (!pg.valid) e = st ? mmuPkg::storeInvalid : mmuPkg::loadInvalid;
            else if (st && !pg.dirty) e = mmuPkg::modified;
            expAddr.push_back({pg.pfn, a[11:0]});
            expUnc.push_back(pg.cca != `CCA_CACHED);
        end
        expExc.push_back(e);
    endtask

    // producer holds the request while memStall is high
    task automatic issue(input [31:0] a, input bit st);
        int n;
        @(posedge clk);
        predict(a, st);
        reqAddr  <= a;
        reqRead  <= !st;
        reqStore <= st;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (memStall && n < 20);
        if (memStall) begin
            errors++;
            $display("%s: timeout, memStall never dropped", testName);
        end
    endtask

    task automatic drain();
        int n;
        @(posedge clk);
        reqRead  <= 1'b0;
        reqStore <= 1'b0;
        n = 0;
        while (expAddr.size() != 0 && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (expAddr.size() != 0) begin
            errors++;
            $display("%s: timeout, %0d responses never arrived", testName, expAddr.size());
        end
    endtask

    task automatic writeEntry(input int idx, input [18:0] vpn2, input mmuPkg::pageAttr p0, p1);
        @(posedge clk);
        tlbWrite      <= 1'b1;
        tlbWriteIndex <= idx[`TLB_INDEX_W-1:0];
        tlbWriteVpn2  <= vpn2;
        tlbWritePage0 <= p0;
        tlbWritePage1 <= p1;
        @(posedge clk);
        tlbWrite <= 1'b0;
        mUsed[idx] = 1'b1;
        mVpn2[idx] = vpn2;
        mPage0[idx] = p0;
        mPage1[idx] = p1;
    endtask

    task automatic stallsSince(input int start, input int want);
        assert (stallCycles - start == want) else begin
            errors++;
            $display("ERROR %s: stall cycles expected %0d actual %0d", testName, want,
                     stallCycles - start);
        end
    endtask

    always @(negedge clk) begin
        if (!reset && memStall) stallCycles++;
        if (!reset && respValid) begin
            if (expAddr.size() == 0) begin
                errors++;
                $display("%s: respValid without a pending request", testName);
            end else begin
                checks++;
                assert (respPhysAddr == expAddr[0]) else begin
                    errors++;
                    $display("ERROR %s: address expected %h actual %h", testName, expAddr[0],
                             respPhysAddr);
                end
                assert (respUncached == expUnc[0]) else begin
                    errors++;
                    $display("ERROR %s: uncached expected %0b actual %0b", testName, expUnc[0],
                             respUncached);
                end
                assert (respExcCode == expExc[0]) else begin
                    errors++;
                    $display("ERROR %s: exc code expected %h actual %h", testName, expExc[0],
                             respExcCode);
                end
                assert (respException == (expExc[0] != mmuPkg::noEx)) else begin
                    errors++;
                    $display("ERROR %s: exception expected %0b actual %0b", testName,
                             expExc[0] != mmuPkg::noEx, respException);
                end
                void'(expAddr.pop_front());
                void'(expUnc.pop_front());
                void'(expExc.pop_front());
            end
        end
    end

    initial begin
        reset <= 1'b1;
        reqAddr <= '0;
        reqRead <= 1'b0;
        reqStore <= 1'b0;
        kseg0Cca <= `CCA_CACHED;
        tlbWrite <= 1'b0;
        tlbWriteIndex <= '0;
        tlbWriteVpn2 <= '0;
        tlbWritePage0 <= '0;
        tlbWritePage1 <= '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        testName = "unmapped";
        s0 = stallCycles;
        for (int i = 0; i < 16; i++) begin
            if (i == 8) begin
                drain();
                @(posedge clk);
                kseg0Cca <= 3'd2; // kseg0 now uncached
            end
            r = lcg();
            issue({2'b10, i[0], r[28:0]}, r[30]);
        end
        drain();
        stallsSince(s0, 0);

        testName = "mapped hit";
        writeEntry(1, 19'h00010, page(20'h12345, 3'd3, 1, 1), page(20'h54321, 3'd2, 1, 1));
        s0 = stallCycles;
        issue({19'h00010, 1'b0, 12'habc}, 1'b0);
        issue({19'h00010, 1'b1, 12'h123}, 1'b1);
        drain();
        stallsSince(s0, 2);
        s0 = stallCycles;
        repeat (6) begin
            r = lcg();
            issue({19'h00010, r[12], r[11:0]}, r[20]);
        end
        drain();
        stallsSince(s0, 0);

        testName = "refill";
        s0 = stallCycles;
        issue({19'h70000, 1'b0, 12'h010}, 1'b0);
        issue({19'h70000, 1'b1, 12'h020}, 1'b1); // buffered miss, no new stall
        drain();
        stallsSince(s0, 2);

        testName = "permission";
        writeEntry(2, 19'h00020, page(20'h0aaaa, 3'd3, 0, 0), page(20'h0bbbb, 3'd3, 0, 1));
        issue({19'h00020, 1'b0, 12'h100}, 1'b0);
        issue({19'h00020, 1'b0, 12'h104}, 1'b1);
        issue({19'h00020, 1'b1, 12'h108}, 1'b1);
        issue({19'h00020, 1'b1, 12'h10c}, 1'b0);
        drain();

        testName = "flush";
        s0 = stallCycles;
        issue({19'h00010, 1'b0, 12'h444}, 1'b0);
        drain();
        writeEntry(1, 19'h00010, page(20'h99999, 3'd3, 1, 1), page(20'h88888, 3'd3, 1, 1));
        issue({19'h00010, 1'b0, 12'h444}, 1'b0);
        drain();
        stallsSince(s0, 4);

        testName = "back-pressure";
        writeEntry(3, 19'h00030, page(20'h03030, 3'd3, 1, 1), page(20'h03031, 3'd0, 1, 1));
        for (int i = 0; i < 60; i++) begin
            r = lcg();
            case (r[1:0])
                2'd0: issue({2'b10, r[2], r[28:0]}, r[16]);
                2'd1: issue({19'h00010, r[12], r[11:0]}, r[16]);
                2'd2: issue({r[3] ? 19'h00030 : 19'h00020, r[12], r[11:0]}, r[16]);
                default: issue({17'h14000, r[3:2], r[12], r[11:0]}, r[16]);
            endcase
        end
        drain();

        $display("responses checked: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+src
src/mmuPkg.sv
src/tlbLookupIf.sv
src/requestRegister.sv
src/tlbArray.sv
src/dtlbBuffer.sv
src/translateOutput.sv
src/dataTranslate.sv
verification/dataTranslate_checker.sv
verification/dataTranslate_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dataTranslate_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wall

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)
